// ==== rtl/cachePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache geometry, address field widths and types
// ~~~~~~~~~~~~~~~~~~~~
package cachePkg;

  localparam int numSets = 8;
  localparam int numWays = 8; // each way one superblock
  localparam int wordW   = 32;
  localparam int tagW    = 27; // address bits 31..5

  typedef logic [$clog2(numSets)-1:0] setIdxT;  // address bits 4..2
  typedef logic [$clog2(numWays)-1:0] wayIdxT;
  typedef logic [1:0]                 blockIdT; // address bits 1..0
  typedef logic [tagW-1:0]            tagT;
  typedef logic [wordW-1:0]           wordT;

endpackage

// ==== rtl/compPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// compression factor and superblock slot layout
// ~~~~~~~~~~~~~~~~~~~~
package compPkg;

  // 2'b00 unused
  typedef enum logic [1:0] {
    cfHalf    = 2'b01, // two 16 bit halves per way
    cfQuarter = 2'b10, // four byte lanes per way
    cfNone    = 2'b11  // whole word
  } compFactorT;

  localparam int slotW = 4;
  localparam int halfW = 16;
  localparam int laneW = 8;

  // quarter: presence bit per lane
  // half: low half id in [1:0], high half id in [3:2]
  // none: stored block id in [1:0]
  typedef logic [slotW-1:0] slotT;

  typedef logic [1:0] halfValidT; // bit 0 low half, bit 1 high half

endpackage

// ==== rtl/accessDecode.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// stage 1, access capture and factor classify
// ~~~~~~~~~~~~~~~~~~~~
module accessDecode import cachePkg::*; import compPkg::*; (
  input  logic       clk_10,
  input  logic       rst,
  input  logic       access,
  input  wordT       address,
  input  wordT       fillData,
  output logic       s1Valid,
  output tagT        s1Tag,
  output setIdxT     s1Set,
  output blockIdT    s1Block,
  output wordT       s1Word,
  output compFactorT s1Cf
);

  compFactorT wordCf;

  // smallest factor the fill word fits in, zero word lands in quarter
  always_comb begin
    if (fillData[wordW-1:laneW] == '0)
      wordCf = cfQuarter;
    else if (fillData[wordW-1:halfW] == '0)
      wordCf = cfHalf;
    else
      wordCf = cfNone;
  end

  always_ff @(posedge clk_10) begin
    if (rst)
      s1Valid <= 1'b0;
    else
      s1Valid <= access; // one cycle pulse in, one cycle pulse out
  end

  always_ff @(posedge clk_10) begin
    if (access) begin
      s1Tag   <= address[wordW-1 -: tagW];
      s1Set   <= address[$bits(blockIdT) +: $bits(setIdxT)];
      s1Block <= address[$bits(blockIdT)-1:0];
      s1Word  <= fillData;
      s1Cf    <= wordCf;
    end
  end

endmodule

// ==== rtl/superblockStore.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// tag, data, valid and LRU arrays
// ~~~~~~~~~~~~~~~~~~~~
module superblockStore import cachePkg::*; import compPkg::*; (
  input  logic               clk_10,
  input  logic               rst,
  input  setIdxT             rdSet,
  input  logic               wrEn,
  input  setIdxT             wrSet,
  input  wayIdxT             wrWay,
  input  tagT                wrTag,
  input  compFactorT         wrCf,
  input  slotT               wrSlots,
  input  halfValidT          wrHalfValid,
  input  wordT               wrData,
  input  logic               touchEn,
  input  setIdxT             touchSet,
  input  wayIdxT             touchWay,
  output tagT                rdTags [numWays],
  output compFactorT         rdCf [numWays],
  output slotT               rdSlots [numWays],
  output halfValidT          rdHalfValid [numWays],
  output logic [numWays-1:0] rdValid,
  output wordT               rdData [numWays],
  output wayIdxT             rdLruWay
);

  tagT                tagArr   [numSets][numWays];
  compFactorT         cfArr    [numSets][numWays];
  slotT               slotArr  [numSets][numWays];
  halfValidT          hvArr    [numSets][numWays];
  wordT               dataArr  [numSets][numWays];
  logic [numWays-1:0] validArr [numSets];
  wayIdxT             lruArr   [numSets][numWays]; // index 0 most recent

  wayIdxT curList [numWays];
  wayIdxT newList [numWays];
  logic   passed;

  // whole set read, no latency
  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      rdTags[w]      = tagArr[rdSet][w];
      rdCf[w]        = cfArr[rdSet][w];
      rdSlots[w]     = slotArr[rdSet][w];
      rdHalfValid[w] = hvArr[rdSet][w];
      rdData[w]      = dataArr[rdSet][w];
    end
  end

  assign rdValid  = validArr[rdSet];
  assign rdLruWay = lruArr[rdSet][numWays-1]; // tail of list

  assign curList = lruArr[touchSet];

  // move touched way to front, entries ahead of it slide back one
  always_comb begin
    passed     = 1'b0;
    newList[0] = touchWay;
    for (int j = 1; j < numWays; j++) begin
      passed     = passed || (curList[j-1] == touchWay);
      newList[j] = passed ? curList[j] : curList[j-1];
    end
  end

  always_ff @(posedge clk_10) begin
    if (rst) begin
      for (int s = 0; s < numSets; s++) begin
        validArr[s] <= '0;
        for (int w = 0; w < numWays; w++)
          lruArr[s][w] <= wayIdxT'(w); // 0..7 in order
      end
    end else begin
      if (wrEn)
        validArr[wrSet][wrWay] <= 1'b1;
      if (touchEn)
        lruArr[touchSet] <= newList;
    end
  end

  always_ff @(posedge clk_10) begin
    if (wrEn) begin
      tagArr[wrSet][wrWay]  <= wrTag;
      cfArr[wrSet][wrWay]   <= wrCf;
      slotArr[wrSet][wrWay] <= wrSlots;
      hvArr[wrSet][wrWay]   <= wrHalfValid;
      dataArr[wrSet][wrWay] <= wrData;
    end
  end

endmodule

// ==== rtl/tagLookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// stage 2, tag compare, hit and placement choice
// ~~~~~~~~~~~~~~~~~~~~
module tagLookup import cachePkg::*; import compPkg::*; (
  input  logic               clk_10,
  input  logic               rst,
  input  logic               s1Valid,
  input  tagT                s1Tag,
  input  setIdxT             s1Set,
  input  blockIdT            s1Block,
  input  wordT               s1Word,
  input  compFactorT         s1Cf,
  input  tagT                rdTags [numWays],
  input  compFactorT         rdCf [numWays],
  input  slotT               rdSlots [numWays],
  input  halfValidT          rdHalfValid [numWays],
  input  logic [numWays-1:0] rdValid,
  input  wordT               rdData [numWays],
  input  wayIdxT             rdLruWay,
  output logic               s2Valid,
  output logic               s2Hit,
  output wayIdxT             s2Way,
  output logic               s2Merge,
  output setIdxT             s2Set,
  output tagT                s2Tag,
  output blockIdT            s2Block,
  output wordT               s2Word,
  output compFactorT         s2Cf,
  output wordT               s2OldData,
  output slotT               s2OldSlots,
  output halfValidT          s2OldHalfValid
);

  logic [numWays-1:0] tagMatch;
  logic [numWays-1:0] slotHit;
  logic [numWays-1:0] freeSlot;
  logic [numWays-1:0] hitVec;
  logic [numWays-1:0] mergeVec;
  wayIdxT             hitWay;
  wayIdxT             mergeWay;
  wayIdxT             freeWay;
  wayIdxT             pickWay;

  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      tagMatch[w] = rdValid[w] && (rdTags[w] == s1Tag);
      case (rdCf[w])
        cfNone:    slotHit[w] = rdSlots[w][1:0] == s1Block;
        cfHalf:    slotHit[w] = (rdHalfValid[w][0] && rdSlots[w][1:0] == s1Block) ||
                                (rdHalfValid[w][1] && rdSlots[w][3:2] == s1Block);
        cfQuarter: slotHit[w] = rdSlots[w][s1Block]; // lane presence bit
        default:   slotHit[w] = 1'b0;
      endcase
      // half needs any empty half, quarter needs its own lane
      freeSlot[w] = (s1Cf == cfHalf) ? !(&rdHalfValid[w]) : !rdSlots[w][s1Block];
      hitVec[w]   = tagMatch[w] && slotHit[w];
      mergeVec[w] = tagMatch[w] && (rdCf[w] == s1Cf) && (s1Cf != cfNone) && freeSlot[w];
    end
  end

  // lowest way wins, so scan downwards
  always_comb begin
    hitWay   = '0;
    mergeWay = '0;
    freeWay  = '0;
    for (int w = numWays - 1; w >= 0; w--) begin
      if (hitVec[w])
        hitWay = wayIdxT'(w);
      if (mergeVec[w])
        mergeWay = wayIdxT'(w);
      if (!rdValid[w])
        freeWay = wayIdxT'(w);
    end
    if (|hitVec)
      pickWay = hitWay;
    else if (|mergeVec)
      pickWay = mergeWay; // room in a matching superblock
    else if (!(&rdValid))
      pickWay = freeWay;
    else
      pickWay = rdLruWay; // set full, evict tail
  end

  always_ff @(posedge clk_10) begin
    if (rst)
      s2Valid <= 1'b0;
    else
      s2Valid <= s1Valid;
  end

  always_ff @(posedge clk_10) begin
    if (s1Valid) begin
      s2Hit   <= |hitVec;
      s2Merge <= !(|hitVec) && (|mergeVec);
      s2Way   <= pickWay;
      s2Set   <= s1Set;
      s2Tag   <= s1Tag;
      s2Block <= s1Block;
      s2Word  <= s1Word;
      // stored factor on a hit, fill factor otherwise
      s2Cf           <= (|hitVec) ? rdCf[pickWay] : s1Cf;
      s2OldData      <= rdData[pickWay];
      s2OldSlots     <= rdSlots[pickWay];
      s2OldHalfValid <= rdHalfValid[pickWay];
    end
  end

endmodule

// ==== rtl/fillMerge.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// stage 3 hit extract, fill merge and outputs
// ~~~~~~~~~~~~~~~~~~~~
module fillMerge import cachePkg::*; import compPkg::*; (
  input  logic       clk_10,
  input  logic       rst,
  input  logic       s2Valid,
  input  logic       s2Hit,
  input  wayIdxT     s2Way,
  input  logic       s2Merge,
  input  setIdxT     s2Set,
  input  tagT        s2Tag,
  input  blockIdT    s2Block,
  input  wordT       s2Word,
  input  compFactorT s2Cf,
  input  wordT       s2OldData,
  input  slotT       s2OldSlots,
  input  halfValidT  s2OldHalfValid,
  output logic       done,
  output logic       hit,
  output wordT       readData,
  output logic       wrEn,
  output setIdxT     wrSet,
  output wayIdxT     wrWay,
  output tagT        wrTag,
  output compFactorT wrCf,
  output slotT       wrSlots,
  output halfValidT  wrHalfValid,
  output wordT       wrData,
  output logic       touchEn,
  output setIdxT     touchSet,
  output wayIdxT     touchWay
);

  wordT hitWord;

  // pick block out of stored superblock
  always_comb begin
    hitWord = '0;
    case (s2Cf)
      cfHalf:
        if (s2OldHalfValid[1] && s2OldSlots[3:2] == s2Block)
          hitWord[halfW-1:0] = s2OldData[wordW-1:halfW];
        else
          hitWord[halfW-1:0] = s2OldData[halfW-1:0];
      cfQuarter: hitWord[laneW-1:0] = s2OldData[s2Block*laneW +: laneW];
      default:   hitWord = s2OldData; // uncompressed
    endcase
  end

  // new superblock contents on a miss
  always_comb begin
    wrData      = '0;
    wrSlots     = '0;
    wrHalfValid = '0;
    case (s2Cf)
      cfHalf:
        if (s2Merge) begin // second block goes to high half
          wrData      = {s2Word[halfW-1:0], s2OldData[halfW-1:0]};
          wrSlots     = {s2Block, s2OldSlots[1:0]};
          wrHalfValid = {1'b1, s2OldHalfValid[0]};
        end else begin
          wrData[halfW-1:0] = s2Word[halfW-1:0]; // fresh way takes low half
          wrSlots[1:0]      = s2Block;
          wrHalfValid       = 2'b01;
        end
      cfQuarter: begin
        if (s2Merge) begin
          wrData  = s2OldData; // keep other lanes
          wrSlots = s2OldSlots;
        end
        wrData[s2Block*laneW +: laneW] = s2Word[laneW-1:0];
        wrSlots[s2Block]               = 1'b1;
      end
      default: begin
        wrData       = s2Word;
        wrSlots[1:0] = s2Block;
      end
    endcase
  end

  assign wrEn  = s2Valid && !s2Hit;
  assign wrSet = s2Set;
  assign wrWay = s2Way;
  assign wrTag = s2Tag;
  assign wrCf  = s2Cf;

  assign touchEn  = s2Valid; // hit and fill both refresh LRU
  assign touchSet = s2Set;
  assign touchWay = s2Way;

  always_ff @(posedge clk_10) begin
    if (rst) begin
      done     <= 1'b0;
      hit      <= 1'b0;
      readData <= '0;
    end else begin
      done <= s2Valid;
      hit  <= s2Valid && s2Hit;
      if (s2Valid && s2Hit)
        readData <= hitWord; // held across misses
    end
  end

endmodule

// ==== rtl/compressedCacheTop.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// compressed cache top level
// ~~~~~~~~~~~~~~~~~~~~
module compressedCacheTop import cachePkg::*; import compPkg::*; (
  input  logic clk_10,
  input  logic rst,
  input  logic access,
  input  wordT address,
  input  wordT fillData,
  output logic done,
  output logic hit,
  output wordT readData
);

  // stage 1 to lookup
  logic       s1Valid;
  tagT        s1Tag;
  setIdxT     s1Set;
  blockIdT    s1Block;
  wordT       s1Word;
  compFactorT s1Cf;

  // set read
  tagT                rdTags [numWays];
  compFactorT         rdCf [numWays];
  slotT               rdSlots [numWays];
  halfValidT          rdHalfValid [numWays];
  logic [numWays-1:0] rdValid;
  wordT               rdData [numWays];
  wayIdxT             rdLruWay;

  // stage 2 to merge
  logic       s2Valid;
  logic       s2Hit;
  wayIdxT     s2Way;
  logic       s2Merge;
  setIdxT     s2Set;
  tagT        s2Tag;
  blockIdT    s2Block;
  wordT       s2Word;
  compFactorT s2Cf;
  wordT       s2OldData;
  slotT       s2OldSlots;
  halfValidT  s2OldHalfValid;

  // write and touch ports
  logic       wrEn;
  setIdxT     wrSet;
  wayIdxT     wrWay;
  tagT        wrTag;
  compFactorT wrCf;
  slotT       wrSlots;
  halfValidT  wrHalfValid;
  wordT       wrData;
  logic       touchEn;
  setIdxT     touchSet;
  wayIdxT     touchWay;

  accessDecode i_accessDecode (.*);

  superblockStore i_superblockStore (.rdSet(s1Set), .*); // read addressed by stage 1

  tagLookup i_tagLookup (.*);

  fillMerge i_fillMerge (.*);

endmodule

// ==== verif/cacheModel.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// reference model of sets, placement and LRU
// ~~~~~~~~~~~~~~~~~~~~
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// per way: owner tag, factor and the block ids it holds
logic       mValid [numSets][numWays];
tagT        mTag   [numSets][numWays];
compFactorT mCf    [numSets][numWays];
logic [3:0] mHas   [numSets][numWays];    // bit per block id
wordT       mVal   [numSets][numWays][4]; // value per block id
int         mOrder [numSets][numWays];    // way numbers, most recent first
wordT       mLastRead;                    // readData only moves on a hit

function automatic void modelReset();
  for (int s = 0; s < numSets; s++) begin
    for (int w = 0; w < numWays; w++) begin
      mValid[s][w] = 1'b0;
      mHas[s][w]   = '0;
      mOrder[s][w] = w;
    end
  end
  mLastRead = '0;
endfunction

// by value range, zero counts as quarter
function automatic compFactorT factorOf(input wordT d);
  if (d < 32'h100)
    return cfQuarter;
  else if (d < 32'h1_0000)
    return cfHalf;
  else
    return cfNone;
endfunction

// pull way out of the list, put it in front
function automatic void promote(input setIdxT s, input int w);
  int pos;
  pos = 0;
  for (int i = 0; i < numWays; i++)
    if (mOrder[s][i] == w)
      pos = i;
  for (int i = pos; i > 0; i--)
    mOrder[s][i] = mOrder[s][i-1];
  mOrder[s][0] = w;
endfunction

function automatic void modelAccess(input wordT a, input wordT d,
                                    output logic expHit, output wordT expData);
  tagT        t;
  setIdxT     s;
  blockIdT    b;
  compFactorT cf;
  int         way;
  int         room;
  t    = a[31:5];
  s    = a[4:2];
  b    = a[1:0];
  cf   = factorOf(d);
  room = (cf == cfQuarter) ? 4 : 2; // blocks per superblock
  way  = -1;
  for (int w = numWays - 1; w >= 0; w--)
    if (mValid[s][w] && mTag[s][w] == t && mHas[s][w][b])
      way = w;
  expHit = (way >= 0);
  if (expHit) begin
    mLastRead = mVal[s][way][b];
  end else begin
    // same tag and factor with room left comes first
    for (int w = numWays - 1; w >= 0; w--)
      if (mValid[s][w] && mTag[s][w] == t && mCf[s][w] == cf && cf != cfNone &&
          $countones(mHas[s][w]) < room)
        way = w;
    if (way < 0) begin
      for (int w = numWays - 1; w >= 0; w--)
        if (!mValid[s][w])
          way = w;
      if (way < 0)
        way = mOrder[s][numWays-1]; // full set, oldest goes
      mHas[s][way] = '0;
    end
    mValid[s][way]    = 1'b1;
    mTag[s][way]      = t;
    mCf[s][way]       = cf;
    mHas[s][way][b]   = 1'b1;
    mVal[s][way][b]   = d;
  end
  promote(s, way);
  expData = mLastRead;
endfunction

`endif

// ==== verif/cacheTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache testbench with stimulus, checks and report
// ~~~~~~~~~~~~~~~~~~~~
module cacheTb import cachePkg::*; import compPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic clk_10;
  logic rst;
  logic access;
  wordT address;
  wordT fillData;
  logic done;
  logic hit;
  wordT readData;

  logic [31:0] lfsrState;
  logic        expHitQ [$]; // one entry per access in flight
  wordT        expDataQ [$];
  int          waitLimit = 60; // cycles
  int          errorCount;
  int          checkCount;
  int          testCount;
  int          failCount;
  int          testErrBase;
  int          issued;

  `include "cacheModel.svh"

  compressedCacheTop i_compressedCacheTop (.*);

  initial begin
    clk_10 = 1'b0;
    forever #2 clk_10 = ~clk_10; // 4 ns period
  end

  // access at edge k gives done at k+2, sampled at k+3
  assert property (@(posedge clk_10) disable iff (rst) done |-> $past(access, 3))
    else begin
      errorCount++;
      $display("done pulse without an access 2 cycles before it");
    end
  assert property (@(posedge clk_10) disable iff (rst) $past(access, 3) |-> done)
    else begin
      errorCount++;
      $display("access not followed by done 2 cycles later");
    end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1); // right shifting galois step
  endfunction

  // one lfsr step per bit taken
  function automatic wordT randBits(input int n);
    wordT r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r         = {r[wordW-2:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
    return r;
  endfunction

  function automatic wordT mkAddr(input tagT t, input setIdxT s, input blockIdT b);
    return {t, s, b};
  endfunction

  function automatic int spacing();
    return 2 + (issued % 3); // cycles 2..4
  endfunction

  task automatic checkResult();
    logic expHit;
    wordT expData;
    if (expHitQ.size() == 0) begin
      errorCount++;
      $display("done pulse with no access outstanding");
    end else begin
      expHit  = expHitQ.pop_front();
      expData = expDataQ.pop_front();
      checkCount++;
      assert (hit === expHit) else begin
        errorCount++;
        $display("error hit: got %h expected %h", hit, expHit);
      end
      assert (readData === expData) else begin
        errorCount++;
        $display("error readData: got %h expected %h", readData, expData);
      end
    end
  endtask

  always @(posedge clk_10) begin
    #1; // outputs settled
    if (!rst && done)
      checkResult();
  end

  // one access pulse with its expectation queued in order
  task automatic issue(input wordT addr, input wordT data, input int gap);
    logic expHit;
    wordT expData;
    modelAccess(addr, data, expHit, expData);
    expHitQ.push_back(expHit);
    expDataQ.push_back(expData);
    issued++;
    access   = 1'b1;
    address  = addr;
    fillData = data;
    @(posedge clk_10);
    #0.5;
    access = 1'b0;
    repeat (gap - 1) begin
      @(posedge clk_10);
      #0.5;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (expHitQ.size() > 0 && n < waitLimit) begin
      @(posedge clk_10);
      #0.5;
      n++;
    end
    if (expHitQ.size() > 0) begin
      errorCount++;
      $display("timeout: %0d accesses never got done", expHitQ.size());
      expHitQ.delete();
      expDataQ.delete();
    end
  endtask

  task automatic endTest(input string name);
    drain();
    testCount++;
    if (errorCount == testErrBase) begin
      $display("test %s: pass", name);
    end else begin
      failCount++;
      $display("test %s: FAIL with %0d errors", name, errorCount - testErrBase);
    end
    testErrBase = errorCount;
  endtask

  task automatic resetAndFirstMiss();
    assert (done === 1'b0) else begin
      errorCount++;
      $display("error done: got %h expected 0", done);
    end
    assert (hit === 1'b0) else begin
      errorCount++;
      $display("error hit: got %h expected 0", hit);
    end
    assert (readData === '0) else begin
      errorCount++;
      $display("error readData: got %h expected 0", readData);
    end
    issue(mkAddr(27'h0123, 3'd0, 2'd1), 32'h1234_5678, spacing());
    endTest("reset and first miss");
  endtask

  task automatic uncompressedHit();
    issue(mkAddr(27'h0100, 3'd1, 2'd2), 32'hDEAD_BEEF, spacing()); // fill
    issue(mkAddr(27'h0100, 3'd1, 2'd2), 32'h0000_0000, spacing()); // hit returns full word
    issue(mkAddr(27'h0100, 3'd1, 2'd1), 32'hCAFE_F00D, spacing()); // other block misses
    issue(mkAddr(27'h0100, 3'd1, 2'd1), 32'h0000_0000, spacing());
    endTest("uncompressed");
  endtask

  task automatic halfShare();
    issue(mkAddr(27'h0200, 3'd2, 2'd0), 32'h0000_1234, spacing());
    issue(mkAddr(27'h0200, 3'd2, 2'd3), 32'h0000_ABCD, spacing()); // joins way 0
    issue(mkAddr(27'h0200, 3'd2, 2'd0), 32'h0000_0000, spacing());
    issue(mkAddr(27'h0200, 3'd2, 2'd3), 32'h0000_0000, spacing());
    issue(mkAddr(27'h0201, 3'd2, 2'd0), 32'h89AB_CDEF, spacing()); // takes way 1
    issue(mkAddr(27'h0200, 3'd2, 2'd0), 32'h0000_0000, spacing());
    issue(mkAddr(27'h0200, 3'd2, 2'd3), 32'h0000_0000, spacing());
    issue(mkAddr(27'h0201, 3'd2, 2'd0), 32'h0000_0000, spacing());
    // six more tags fill the set exactly when both halves share one way
    for (int i = 0; i < 6; i++)
      issue(mkAddr(tagT'(32'h210 + i), 3'd2, 2'd1), 32'h7700_0000 + i, spacing());
    issue(mkAddr(27'h0200, 3'd2, 2'd0), 32'h0000_0000, spacing());
    issue(mkAddr(27'h0200, 3'd2, 2'd3), 32'h0000_0000, spacing());
    endTest("half");
  endtask

  task automatic quarterMerge();
    for (int i = 0; i < 4; i++)
      issue(mkAddr(27'h0300, 3'd3, blockIdT'(i)), 32'h11 * (i + 1), spacing());
    for (int i = 0; i < 4; i++)
      issue(mkAddr(27'h0300, 3'd3, blockIdT'(i)), 32'h0000_00FF, spacing());
    // seven other tags take the rest, no eviction if the lanes merged
    for (int i = 0; i < 7; i++)
      issue(mkAddr(tagT'(32'h310 + i), 3'd3, 2'd0), 32'h6600_0000 + i, spacing());
    for (int i = 0; i < 4; i++)
      issue(mkAddr(27'h0300, 3'd3, blockIdT'(i)), 32'h0000_00FF, spacing());
    endTest("quarter");
  endtask

  task automatic lruEvict();
    for (int i = 0; i < 8; i++)
      issue(mkAddr(tagT'(32'h400 + i), 3'd4, 2'd0), 32'hA5A5_0000 + i, spacing());
    issue(mkAddr(27'h0400, 3'd4, 2'd0), 32'h0000_0000, spacing()); // touch first
    issue(mkAddr(27'h0408, 3'd4, 2'd0), 32'h5A5A_0008, spacing()); // evicts second
    issue(mkAddr(27'h0400, 3'd4, 2'd0), 32'h0000_0000, spacing());
    issue(mkAddr(27'h0401, 3'd4, 2'd0), 32'h0000_0000, spacing());
    endTest("lru");
  endtask

  // small tag space over sets 6 and 7 at 2 cycle spacing
  task automatic randomTraffic(input int count);
    tagT     rTag;
    setIdxT  rSet;
    blockIdT rBlk;
    wordT    kind;
    wordT    data;
    for (int i = 0; i < count; i++) begin
      rTag = tagT'(randBits(3));
      rSet = randBits(1) ? 3'd6 : 3'd7;
      rBlk = blockIdT'(randBits(2));
      kind = randBits(2);
      case (kind[1:0])
        2'd0, 2'd1: data = randBits(8);  // quarter mostly
        2'd2:       data = randBits(16);
        default:    data = randBits(32);
      endcase
      issue(mkAddr(rTag, rSet, rBlk), data, 2);
    end
    endTest("random");
  endtask

  initial begin
    rst         = 1'b1;
    access      = 1'b0;
    address     = '0;
    fillData    = '0;
    lfsrState   = 32'h9fae9a94;
    errorCount  = 0;
    checkCount  = 0;
    testCount   = 0;
    failCount   = 0;
    testErrBase = 0;
    issued      = 0;
    modelReset();
    repeat (2) @(posedge clk_10);
    #0.5;
    rst = 1'b0;
    @(posedge clk_10);
    #0.5;
    resetAndFirstMiss();
    uncompressedHit();
    halfShare();
    quarterMerge();
    lruEvict();
    randomTraffic(200);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verif
rtl/cachePkg.sv
rtl/compPkg.sv
rtl/accessDecode.sv
rtl/superblockStore.sv
rtl/tagLookup.sv
rtl/fillMerge.sv
rtl/compressedCacheTop.sv
verif/cacheTb.sv

// ==== Makefile ====
# Verilator build and run for the compressed cache testbench

TOP    ?= cacheTb
LOG    ?= sim.log
VFLAGS ?= -O3
OBJDIR ?= obj_dir

BASEFLAGS = --binary --timing --assert --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	verilator $(BASEFLAGS) $(VFLAGS) -f tb.f --top-module $(TOP) -Mdir $(OBJDIR)

# pass only when the log holds the pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
